/* dif_pkg.sv */
// One SKIROC2 with a fixed chip ID and one HV module, field widths and opcodes fixed at build time
package dif_pkg;

	////////////////////
	// Field widths
	////////////////////
	localparam int CHIP_ID_W     = 8;
	localparam int THR_W         = 10;
	localparam int FB_CAP_W      = 4;
	localparam int DELAY_W       = 8;
	localparam int SC_FRAME_BITS = 31;                        // 8 + 10 + 4 + 8 + 1
	localparam int SC_CNT_W      = $clog2(SC_FRAME_BITS);     // Bit counter of the shifter
	localparam int HV_CMD_BYTES  = 7;                         // HBV plus four digits
	localparam int HV_IDX_W      = $clog2(HV_CMD_BYTES);

	// Host word, opcode in upper byte and argument in lower byte
	typedef logic [15:0] cmd_word_t;

	typedef enum logic [7:0] {
		OP_THR_HI   = 8'hA1,  // Threshold bits 9..8
		OP_THR_LO   = 8'hA2,  // Threshold bits 7..0
		OP_FB_CAP   = 8'hA3,
		OP_DELAY    = 8'hA4,
		OP_VAL_EVT  = 8'hA5,  // Discriminator enable
		OP_START_SC = 8'hF0,
		OP_START_HV = 8'hB0,
		OP_HV_D1    = 8'hB1,  // Most significant HV digit
		OP_HV_D2    = 8'hB2,
		OP_HV_D3    = 8'hB3,
		OP_HV_D4    = 8'hB4
	} opcode_t;

	// Slow-control frame, MSB leaves first
	typedef struct packed {
		logic [CHIP_ID_W-1:0] chip_id;
		logic [THR_W-1:0]     dac_thr;
		logic [FB_CAP_W-1:0]  fb_cap;
		logic [DELAY_W-1:0]   delay_trig;  // Bit-reversed on the ASIC side
		logic                 val_evt;
	} sc_frame_t;

	typedef logic [7:0] hv_byte_t;
	typedef logic [3:0][3:0] hv_digits_t;  // Index 3 is digit 1

	////////////////////
	// Constants and reset values
	localparam logic [CHIP_ID_W-1:0] CHIP_ID           = 8'h01;
	localparam logic [DELAY_W-1:0]   DELAY_DEFAULT     = 8'h70;
	localparam logic [THR_W-1:0]     THR_DEFAULT       = 10'h0F0;
	localparam logic                 VAL_EVT_DEFAULT   = 1'b1;
	localparam logic [FB_CAP_W-1:0]  FB_CAP_DEFAULT    = 4'h0;
	localparam hv_digits_t           HV_DIGITS_DEFAULT = '0;
	localparam logic [23:0]          HV_PREFIX         = {8'h48, 8'h42, 8'h56};  // ASCII HBV

endpackage

/* cmd_decode.sv */
// Every strobed word is taken, unknown opcodes are dropped and settings apply one cycle later
`timescale 1ns/100ps

module cmd_decode import dif_pkg::*; (
	input  logic       Clk_Out_2_All,
	input  logic       rst_n_i,
	input  cmd_word_t  cmd_i,        // Opcode and argument
	input  logic       cmd_en_i,     // One cycle per word
	output sc_frame_t  sc_frame_o,   // Live slow-control settings
	output logic       sc_start_o,
	output hv_digits_t hv_digits_o,
	output logic       hv_start_o
);

	opcode_t             opcode;
	logic [7:0]          arg;
	logic [THR_W-1:0]    thr_q;       // Built from two halves
	logic [FB_CAP_W-1:0] fb_cap_q;
	logic [DELAY_W-1:0]  delay_q;     // Host order
	logic [DELAY_W-1:0]  delay_rev;   // ASIC order
	logic                val_evt_q;
	hv_digits_t          hv_digits_q;

	// Split the command word
	assign opcode = opcode_t'(cmd_i[15:8]);
	assign arg    = cmd_i[7:0];

	////////////////////
	// Setting registers
	////////////////////
	always_ff @(posedge Clk_Out_2_All or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			thr_q       <= THR_DEFAULT;
			fb_cap_q    <= FB_CAP_DEFAULT;
			delay_q     <= DELAY_DEFAULT;
			val_evt_q   <= VAL_EVT_DEFAULT;   // Discriminator on
			hv_digits_q <= HV_DIGITS_DEFAULT;
		end
		else if (cmd_en_i)
		begin
			case (opcode)
				OP_THR_HI:  thr_q[9:8]     <= arg[1:0];
				OP_THR_LO:  thr_q[7:0]     <= arg;
				OP_FB_CAP:  fb_cap_q       <= arg[3:0];
				OP_DELAY:   delay_q        <= arg;
				OP_VAL_EVT: val_evt_q      <= arg[0];
				OP_HV_D1:   hv_digits_q[3] <= arg[3:0];   // Highest digit
				OP_HV_D2:   hv_digits_q[2] <= arg[3:0];
				OP_HV_D3:   hv_digits_q[1] <= arg[3:0];
				OP_HV_D4:   hv_digits_q[0] <= arg[3:0];   // Lowest digit
				default:    ;                             // Starts and unknown codes
			endcase
		end
	end

	////////////////////
	// Start pulses
	////////////////////
	always_ff @(posedge Clk_Out_2_All or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			sc_start_o <= 1'b0;
			hv_start_o <= 1'b0;
		end
		else
		begin
			sc_start_o <= cmd_en_i && (opcode == OP_START_SC);  // One cycle wide
			hv_start_o <= cmd_en_i && (opcode == OP_START_HV);
		end
	end

	// The ASIC expects the trigger delay LSB first
	assign delay_rev = {<<{delay_q}};

	// Frame with the fixed chip ID in front
	assign sc_frame_o = '{
		chip_id:    CHIP_ID,
		dac_thr:    thr_q,
		fb_cap:     fb_cap_q,
		delay_trig: delay_rev,
		val_evt:    val_evt_q
	};

	assign hv_digits_o = hv_digits_q;

endmodule

/* sc_shift.sv */
// Two system clocks per bit, MSB first, and starts during a shift or its done tail are dropped
`timescale 1ns/100ps

module sc_shift import dif_pkg::*; (
	input  logic      Clk_Out_2_All,
	input  logic      rst_n_i,
	input  sc_frame_t sc_frame_i,   // Sampled at start only
	input  logic      sc_start_i,
	output logic      sr_ck_o,      // ASIC shift clock
	output logic      sr_in_o,      // ASIC shift data
	output logic      sc_done_o
);

	logic [SC_FRAME_BITS-1:0] shreg_q;     // Current bit at the top
	logic [SC_CNT_W-1:0]      bit_cnt_q;
	logic                     busy_q;
	logic                     tail_q;      // Gap cycle before done
	logic                     load;
	logic                     last_bit;

	assign load     = sc_start_i && !busy_q;
	assign last_bit = (bit_cnt_q == SC_CNT_W'(SC_FRAME_BITS - 1));

	// Frame snapshot, moves up after each high clock
	always_ff @(posedge Clk_Out_2_All)
	begin
		if (load)
			shreg_q <= sc_frame_i;
		else if (sr_ck_o)
			shreg_q <= {shreg_q[SC_FRAME_BITS-2:0], 1'b0};
	end

	////////////////////
	// Shift sequencer
	////////////////////
	always_ff @(posedge Clk_Out_2_All or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			busy_q    <= 1'b0;
			tail_q    <= 1'b0;
			bit_cnt_q <= '0;
			sr_ck_o   <= 1'b0;
			sr_in_o   <= 1'b0;
			sc_done_o <= 1'b0;
		end
		else
		begin
			sc_done_o <= 1'b0;
			if (load)
			begin
				busy_q    <= 1'b1;
				bit_cnt_q <= '0;
				sr_in_o   <= sc_frame_i[SC_FRAME_BITS-1];  // First bit set up while clock low
			end
			else if (tail_q)
			begin
				tail_q    <= 1'b0;
				busy_q    <= 1'b0;
				sc_done_o <= 1'b1;   // Two cycles after the last high clock
				sr_in_o   <= 1'b0;
			end
			else if (busy_q)
			begin
				if (!sr_ck_o)
					sr_ck_o <= 1'b1;    // High phase, one cycle
				else
				begin
					sr_ck_o <= 1'b0;
					if (last_bit)
						tail_q <= 1'b1;
					else
					begin
						bit_cnt_q <= bit_cnt_q + 1'b1;
						sr_in_o   <= shreg_q[SC_FRAME_BITS-2];  // Next bit in low phase
					end
				end
			end
		end
	end

endmodule

/* hv_cmd_builder.sv */
// Seven ASCII bytes per start on a valid/ready port, starts are dropped while a command is out
`timescale 1ns/100ps

module hv_cmd_builder import dif_pkg::*; (
	input  logic       Clk_Out_2_All,
	input  logic       rst_n_i,
	input  hv_digits_t hv_digits_i,
	input  logic       hv_start_i,
	output hv_byte_t   hv_byte_o,    // Valid only with hv_valid_o
	output logic       hv_valid_o,
	input  logic       hv_ready_i    // Byte leaves when both high
);

	hv_digits_t          digits_q;    // Snapshot for this command
	logic [HV_IDX_W-1:0] idx_q;       // Byte in flight
	logic [3:0]          digit;
	logic                last_byte;

	// Digit value to ASCII, capital letters above 9
	function automatic hv_byte_t hex_to_ascii(input logic [3:0] hex);
		if (hex < 4'd10)
			hex_to_ascii = 8'h30 + {4'h0, hex};
		else
			hex_to_ascii = 8'h37 + {4'h0, hex};
	endfunction

	assign last_byte = (idx_q == HV_IDX_W'(HV_CMD_BYTES - 1));

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (hv_start_i && !hv_valid_o)
			digits_q <= hv_digits_i;
	end

	////////////////////
	// Byte handshake
	////////////////////
	always_ff @(posedge Clk_Out_2_All or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			hv_valid_o <= 1'b0;
			idx_q      <= '0;
		end
		else if (!hv_valid_o)
		begin
			if (hv_start_i)
			begin
				hv_valid_o <= 1'b1;   // First byte next cycle
				idx_q      <= '0;
			end
		end
		else if (hv_ready_i)
		begin
			if (last_byte)
				hv_valid_o <= 1'b0;  // Seventh byte gone
			else
				idx_q <= idx_q + 1'b1;
		end
	end

	// Byte follows the index, so it holds while stalled
	always_comb
	begin
		case (idx_q)
			3'd3:    digit = digits_q[3];
			3'd4:    digit = digits_q[2];
			3'd5:    digit = digits_q[1];
			default: digit = digits_q[0];
		endcase
		case (idx_q)
			3'd0:    hv_byte_o = HV_PREFIX[23:16];   // H
			3'd1:    hv_byte_o = HV_PREFIX[15:8];    // B
			3'd2:    hv_byte_o = HV_PREFIX[7:0];     // V
			default: hv_byte_o = hex_to_ascii(digit);
		endcase
	end

endmodule

/* skiroc_dif_top.sv */
// Single clock core with no back-pressure on commands and HV bytes handed out raw without a UART
`timescale 1ns/100ps

module skiroc_dif_top import dif_pkg::*; (
	input  logic      Clk_Out_2_All,
	input  logic      rst_n_i,
	input  cmd_word_t cmd_i,
	input  logic      cmd_en_i,
	output logic      sr_ck_o,
	output logic      sr_in_o,
	output logic      sc_done_o,
	output hv_byte_t  hv_byte_o,
	output logic      hv_valid_o,
	input  logic      hv_ready_i
);

	sc_frame_t  sc_frame;    // Decode to shifter
	logic       sc_start;
	hv_digits_t hv_digits;   // Decode to HV builder
	logic       hv_start;

	cmd_decode u_cmd_decode (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_n_i       (rst_n_i),
		.cmd_i         (cmd_i),
		.cmd_en_i      (cmd_en_i),
		.sc_frame_o    (sc_frame),
		.sc_start_o    (sc_start),
		.hv_digits_o   (hv_digits),
		.hv_start_o    (hv_start)
	);

	// ASIC slow-control pins
	sc_shift u_sc_shift (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_n_i       (rst_n_i),
		.sc_frame_i    (sc_frame),
		.sc_start_i    (sc_start),
		.sr_ck_o       (sr_ck_o),
		.sr_in_o       (sr_in_o),
		.sc_done_o     (sc_done_o)
	);

	hv_cmd_builder u_hv_cmd_builder (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_n_i       (rst_n_i),
		.hv_digits_i   (hv_digits),
		.hv_start_i    (hv_start),
		.hv_byte_o     (hv_byte_o),
		.hv_valid_o    (hv_valid_o),
		.hv_ready_i    (hv_ready_i)
	);

endmodule

/* tb_skiroc_dif_assert.sv */
// Inputs unused at a bind site are tied idle there, checks are off while rst_n_i is low
`timescale 1ns/100ps

module tb_skiroc_dif_assert import dif_pkg::*; (
	input logic     Clk_Out_2_All,
	input logic     rst_n_i,
	input logic     sr_ck_i,
	input logic     sc_done_i,
	input hv_byte_t hv_byte_i,
	input logic     hv_valid_i,
	input logic     hv_ready_i
);

	////////////////////
	// ASIC shift pins
	sr_ck_one_cycle: assert property (@(posedge Clk_Out_2_All) disable iff (!rst_n_i)
		sr_ck_i |=> !sr_ck_i)
		else $error("sr_ck_o high for two cycles in a row");

	done_apart: assert property (@(posedge Clk_Out_2_All) disable iff (!rst_n_i)
		!(sc_done_i && sr_ck_i))   // Done only after the last pulse
		else $error("sc_done_o together with sr_ck_o");

	////////////////////
	// HV byte held while stalled
	hv_hold: assert property (@(posedge Clk_Out_2_All) disable iff (!rst_n_i)
		(hv_valid_i && !hv_ready_i) |=> (hv_valid_i && $stable(hv_byte_i)))
		else $error("HV byte or valid changed under back-pressure");

endmodule

/* tb_skiroc_dif.sv */
// Table rows run in order with one command word per cycle and one shift or HV command per row
`timescale 1ns/100ps

module tb_skiroc_dif import dif_pkg::*; ();

	localparam int N_ROWS         = 5;
	localparam int TIMEOUT_CYCLES = 200 * N_ROWS + 20;   // Per row budget plus reset

	logic      Clk_Out_2_All;
	logic      rst_n_i;
	cmd_word_t cmd_i;
	logic      cmd_en_i;
	logic      hv_ready_i;
	logic      sr_ck;
	logic      sr_in;
	logic      sc_done;
	hv_byte_t  hv_byte;
	logic      hv_valid;

	////////////////////
	// Stimulus table
	string     names [N_ROWS];
	cmd_word_t cmds [N_ROWS][8];
	int        n_cmds [N_ROWS];
	bit        is_hv [N_ROWS];       // HV bytes, else SC frame

	// Reference model state
	logic [THR_W-1:0] m_thr;
	logic [3:0]       m_fb;
	logic [7:0]       m_delay;
	logic             m_val;
	logic [3:0]       m_dig [4];      // Index 0 is digit 1
	sc_frame_t        exp_frame;
	sc_frame_t        got_frame;      // Bits seen on sr_in
	hv_byte_t         exp_bytes [HV_CMD_BYTES];
	bit               sc_armed;
	bit               sc_done_seen;
	int               sc_bits;
	int               hv_cnt;         // Bytes taken so far
	int               cycle_cnt = 0;
	integer           seed;
	string            test_name;

	skiroc_dif_top dut_i (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_n_i       (rst_n_i),
		.cmd_i         (cmd_i),
		.cmd_en_i      (cmd_en_i),
		.sr_ck_o       (sr_ck),
		.sr_in_o       (sr_in),
		.sc_done_o     (sc_done),
		.hv_byte_o     (hv_byte),
		.hv_valid_o    (hv_valid),
		.hv_ready_i    (hv_ready_i)
	);

	// Shifter side, HV inputs tied idle
	bind sc_shift tb_skiroc_dif_assert sc_checks (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_n_i       (rst_n_i),
		.sr_ck_i       (sr_ck_o),
		.sc_done_i     (sc_done_o),
		.hv_byte_i     (8'h00),
		.hv_valid_i    (1'b0),
		.hv_ready_i    (1'b1)
	);

	bind hv_cmd_builder tb_skiroc_dif_assert hv_checks (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_n_i       (rst_n_i),
		.sr_ck_i       (1'b0),
		.sc_done_i     (1'b0),
		.hv_byte_i     (hv_byte_o),
		.hv_valid_i    (hv_valid_o),
		.hv_ready_i    (hv_ready_i)
	);

	always #4 Clk_Out_2_All = ~Clk_Out_2_All;   // 8 ns

	always @(posedge Clk_Out_2_All)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			report_failure($sformatf("Timeout after %0d cycles, test %s never ended", cycle_cnt,
				test_name));
	end

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_sc_frame(input sc_frame_t exp_v, input sc_frame_t act_v);
		if (act_v !== exp_v)
			report_failure($sformatf("** Error %s: expected %h, actual %h", test_name, exp_v, act_v));
	endtask

	task automatic check_hv_byte(input hv_byte_t exp_v, input hv_byte_t act_v);
		if (act_v !== exp_v)
			report_failure($sformatf("** Error %s: expected %h, actual %h", test_name, exp_v, act_v));
	endtask

	function automatic logic [7:0] reverse8(input logic [7:0] v);
		for (int i = 0; i < 8; i++)
			reverse8[i] = v[7-i];
	endfunction

	// 0..9 to digits, 10..15 to capitals
	function automatic hv_byte_t hex_char(input logic [3:0] d);
		if (d < 4'd10)
			hex_char = 8'h30 + {4'h0, d};
		else
			hex_char = 8'h41 + {4'h0, d} - 8'd10;
	endfunction

	function automatic sc_frame_t model_frame();
		model_frame = '{chip_id: 8'h01, dac_thr: m_thr, fb_cap: m_fb,
			delay_trig: reverse8(m_delay), val_evt: m_val};
	endfunction

	////////////////////
	// Model update per strobed word
	task automatic update_model(input cmd_word_t w);
		case (w[15:8])
			OP_THR_HI:   m_thr[9:8] = w[1:0];
			OP_THR_LO:   m_thr[7:0] = w[7:0];
			OP_FB_CAP:   m_fb = w[3:0];
			OP_DELAY:    m_delay = w[7:0];
			OP_VAL_EVT:  m_val = w[0];
			OP_HV_D1:    m_dig[0] = w[3:0];
			OP_HV_D2:    m_dig[1] = w[3:0];
			OP_HV_D3:    m_dig[2] = w[3:0];
			OP_HV_D4:    m_dig[3] = w[3:0];
			OP_START_SC:
				if (!sc_armed)
				begin
					exp_frame = model_frame();   // Later words miss this frame
					sc_armed  = 1'b1;
					sc_bits   = 0;
				end
			OP_START_HV:
				if (hv_cnt >= HV_CMD_BYTES)      // Ignored while bytes pending
				begin
					exp_bytes[0] = "H";
					exp_bytes[1] = "B";
					exp_bytes[2] = "V";
					for (int i = 0; i < 4; i++)
						exp_bytes[3 + i] = hex_char(m_dig[i]);
					hv_cnt = 0;
				end
			default: ;                            // Unknown codes change nothing
		endcase
	endtask

	// Outputs are settled at the falling edge
	task automatic sample_outputs();
		if (sr_ck)
		begin
			if (!sc_armed)
				report_failure("Shift clock pulsed with no slow-control start pending");
			got_frame = {got_frame[SC_FRAME_BITS-2:0], sr_in};
			sc_bits++;
		end
		if (sc_done)
		begin
			if (!sc_armed || sc_bits != SC_FRAME_BITS)
				report_failure($sformatf("Done pulse in %s after %0d shift clocks", test_name,
					sc_bits));
			check_sc_frame(exp_frame, got_frame);
			sc_armed     = 1'b0;
			sc_done_seen = 1'b1;
		end
		if (hv_valid && hv_cnt >= HV_CMD_BYTES)
			report_failure("HV byte offered with no HV command pending");
		if (hv_valid && hv_ready_i)      // Byte leaves at the coming rising edge
		begin
			check_hv_byte(exp_bytes[hv_cnt], hv_byte);
			hv_cnt++;
		end
	endtask

	task automatic step_cycle(input cmd_word_t w, input bit en);
		@(negedge Clk_Out_2_All);
		hv_ready_i = 1'($random(seed));   // Random back-pressure for the next edge
		sample_outputs();
		cmd_i      = w;
		cmd_en_i   = en;
		if (en)
			update_model(w);
	endtask

	////////////////////
	task automatic load_table();
		names[0] = "sc_default";      // Start only
		cmds[0]  = '{16'hF000, 16'h0000, 16'h0000, 16'h0000,
			16'h0000, 16'h0000, 16'h0000, 16'h0000};
		names[1] = "sc_settings";     // Two unknown opcodes mixed in
		cmds[1]  = '{16'hA102, 16'hA25A, 16'h77AA, 16'hA30B,
			16'hA42D, 16'hA500, 16'h12FF, 16'hF000};
		names[2] = "sc_busy_start";   // Writes and a start during the shift
		cmds[2]  = '{16'hA233, 16'hF000, 16'hA101, 16'hA4C4,
			16'hA307, 16'hF000, 16'hA501, 16'h0000};
		names[3] = "sc_next_start";
		cmds[3]  = '{16'hF000, 16'h0000, 16'h0000, 16'h0000,
			16'h0000, 16'h0000, 16'h0000, 16'h0000};
		names[4] = "hv_digits";       // Digits 9 A 3 F
		cmds[4]  = '{16'hB109, 16'hB20A, 16'hB303, 16'hB40F,
			16'hB000, 16'h0000, 16'h0000, 16'h0000};
		n_cmds   = '{1, 8, 7, 1, 5};
		is_hv    = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
	endtask

	initial
	begin
		Clk_Out_2_All = 1'b0;
		rst_n_i       = 1'b0;
		cmd_i         = '0;
		cmd_en_i      = 1'b0;
		hv_ready_i    = 1'b0;
		seed          = 71;
		m_thr         = 10'h0F0;   // Reset defaults
		m_fb          = 4'h0;
		m_delay       = 8'h70;
		m_val         = 1'b1;
		m_dig         = '{4'h0, 4'h0, 4'h0, 4'h0};
		exp_frame     = '0;
		got_frame     = '0;
		sc_armed      = 1'b0;
		sc_done_seen  = 1'b0;
		sc_bits       = 0;
		hv_cnt        = HV_CMD_BYTES;
		test_name     = "reset";
		load_table();
		repeat (4) @(negedge Clk_Out_2_All);
		if (sr_ck || sr_in || sc_done || hv_valid)
			report_failure("Shift pins, done or HV valid not low after reset");
		rst_n_i = 1'b1;
		for (int r = 0; r < N_ROWS; r++)
		begin
			test_name    = names[r];
			sc_done_seen = 1'b0;
			for (int k = 0; k < n_cmds[r]; k++)
				step_cycle(cmds[r][k], 1'b1);
			if (is_hv[r])
				while (hv_cnt < HV_CMD_BYTES)
					step_cycle(16'h0000, 1'b0);
			else
				while (!sc_done_seen)
					step_cycle(16'h0000, 1'b0);
			step_cycle(16'h0000, 1'b0);   // Valid must be low by now
		end
		$display("Verification passed");
		$finish;
	end

endmodule

/* skiroc_dif_top.f */
dif_pkg.sv
cmd_decode.sv
sc_shift.sv
hv_cmd_builder.sv
skiroc_dif_top.sv
tb_skiroc_dif_assert.sv
tb_skiroc_dif.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module tb_skiroc_dif -f skiroc_dif_top.f \
	-o tb_skiroc_dif &&
./obj_dir/tb_skiroc_dif ||
exit 1
